//--- common/tcdm_pkg.sv
// Shared types for the strided TCDM load engine.
// Holds the data, address and length widths, FIFO flags and the two halves
// of a TCDM port.

package tcdm_pkg;

  // one data word of the memory and of the output stream.
  typedef logic [31:0] word_t;

  // word address into the bank.
  typedef logic [15:0] addr_t;

  // transfer length in words, also used for the stride.
  typedef logic [15:0] count_t;

  // status of a stream FIFO.
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

  // Request half of a TCDM port.
  // It is driven by the requester and must stay stable until granted.
  typedef struct packed {
    logic  req;
    addr_t add;
  } tcdm_req_t;

  // Response half of a TCDM port.
  // r_valid follows a granted request by exactly one cycle.
  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    word_t r_data;
  } tcdm_rsp_t;

endpackage

//--- source/stream_fifo.sv
// Synchronous first-word-fall-through FIFO.
// Push and pop are single-cycle strobes; the oldest word is always on data_o.

`timescale 1ns/1ns

module stream_fifo #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   push_i,
  input  logic [DATA_WIDTH-1:0]  data_i,
  input  logic                   pop_i,
  output logic [DATA_WIDTH-1:0]  data_o,
  output tcdm_pkg::fifo_flags_t  flags_o
);

  localparam int unsigned PTR_WIDTH = $clog2(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_WIDTH:0]    wr_ptr_q;  // top bit is the wrap flag.
  logic [PTR_WIDTH:0]    rd_ptr_q;
  logic                  empty;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  // same index, wrap bits tell whether the writer is a lap ahead.
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[PTR_WIDTH] != rd_ptr_q[PTR_WIDTH]) &&
                 (wr_ptr_q[PTR_WIDTH-1:0] == rd_ptr_q[PTR_WIDTH-1:0]);

  assign do_push = push_i & ~full;  // a push into a full FIFO is dropped.
  assign do_pop  = pop_i & ~empty;  // a pop from an empty FIFO does nothing.

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else if (clear_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      mem_q[wr_ptr_q[PTR_WIDTH-1:0]] <= data_i;
    end
  end

  assign data_o        = mem_q[rd_ptr_q[PTR_WIDTH-1:0]];
  assign flags_o.empty = empty;
  assign flags_o.full  = full;

endmodule

//--- tcdm_fifo_load/tcdm_fifo_load.sv
// Load-side TCDM decoupler.
// Buffers requests toward memory and responses toward the consumer in two
// FIFOs, with a holding register for a response that finds no room.

`timescale 1ns/1ns

module tcdm_fifo_load #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  ready_i,
  input  tcdm_pkg::tcdm_req_t   up_req_i,
  output tcdm_pkg::tcdm_rsp_t   up_rsp_o,
  output tcdm_pkg::tcdm_req_t   mem_req_o,
  input  tcdm_pkg::tcdm_rsp_t   mem_rsp_i,
  output tcdm_pkg::fifo_flags_t flags_o
);

  localparam int unsigned WORD_WIDTH = $bits(tcdm_pkg::word_t);
  localparam int unsigned ADDR_WIDTH = $bits(tcdm_pkg::addr_t);

  tcdm_pkg::fifo_flags_t flags_outgoing;
  tcdm_pkg::fifo_flags_t flags_incoming;
  tcdm_pkg::word_t       out_push_data;
  tcdm_pkg::word_t       out_pop_data;
  tcdm_pkg::word_t       in_push_data;
  tcdm_pkg::word_t       in_pop_data;
  tcdm_pkg::word_t       hold_data_q;
  logic                  hold_valid_q;
  logic                  drop_q;
  logic                  rsp_valid;
  logic                  in_push;
  logic                  in_pop;

  // outgoing path, addresses from the requester to the bank.
  assign out_push_data = tcdm_pkg::word_t'(up_req_i.add);
  assign up_rsp_o.gnt  = ~flags_outgoing.full;

  stream_fifo #(
    .DATA_WIDTH ( WORD_WIDTH ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo_outgoing (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .clear_i ( clear_i        ),
    .push_i  ( up_req_i.req   ),
    .data_i  ( out_push_data  ),
    .pop_i   ( mem_rsp_i.gnt  ),
    .data_o  ( out_pop_data   ),
    .flags_o ( flags_outgoing )
  );

  // no new request while the incoming side is full, so at most one response
  // can be in flight without room and the holding register covers it.
  assign mem_req_o.req = ~flags_outgoing.empty & ~flags_incoming.full;
  assign mem_req_o.add = out_pop_data[ADDR_WIDTH-1:0];

  // a response to a request granted during clear belongs to the old load.
  assign rsp_valid    = mem_rsp_i.r_valid & ~drop_q;
  assign in_push      = rsp_valid | hold_valid_q;
  assign in_push_data = rsp_valid ? mem_rsp_i.r_data : hold_data_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hold_valid_q <= 1'b0;
      drop_q       <= 1'b0;
    end
    else
    begin
      hold_valid_q <= ~clear_i & in_push & flags_incoming.full;  // word found no room.
      drop_q       <= clear_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (in_push & flags_incoming.full)
    begin
      hold_data_q <= in_push_data;
    end
  end

  // incoming path, data from the bank to the consumer.
  stream_fifo #(
    .DATA_WIDTH ( WORD_WIDTH ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo_incoming (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .clear_i ( clear_i        ),
    .push_i  ( in_push        ),
    .data_i  ( in_push_data   ),
    .pop_i   ( in_pop         ),
    .data_o  ( in_pop_data    ),
    .flags_o ( flags_incoming )
  );

  assign in_pop           = ~flags_incoming.empty & ready_i;  // one word per ready cycle.
  assign up_rsp_o.r_valid = in_pop;
  assign up_rsp_o.r_data  = in_pop_data;

  assign flags_o.empty = flags_incoming.empty & flags_outgoing.empty;
  assign flags_o.full  = flags_outgoing.full;

endmodule

//--- source/load_addr_gen.sv
// Strided load address generator.
// Issues count requests from base in steps of stride, then waits until
// every word has been delivered and pulses done.

`timescale 1ns/1ns

module load_addr_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  tcdm_pkg::addr_t     base_i,
  input  tcdm_pkg::count_t    stride_i,
  input  tcdm_pkg::count_t    count_i,
  output tcdm_pkg::tcdm_req_t req_o,
  input  tcdm_pkg::tcdm_rsp_t rsp_i,
  output logic                busy_o,
  output logic                done_o
);

  typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_e;

  state_e           state_q;
  tcdm_pkg::addr_t  addr_q;
  tcdm_pkg::count_t stride_q;
  tcdm_pkg::count_t count_q;
  tcdm_pkg::count_t issued_q;
  tcdm_pkg::count_t rcvd_q;
  logic             done_q;
  logic             granted;
  logic             received;

  assign granted  = req_o.req & rsp_i.gnt;
  assign received = (state_q != IDLE) & rsp_i.r_valid;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q  <= IDLE;
      addr_q   <= '0;
      stride_q <= '0;
      count_q  <= '0;
      issued_q <= '0;
      rcvd_q   <= '0;
      done_q   <= 1'b0;
    end
    else if (clear_i)
    begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (state_q == IDLE)
      begin
        if (start_i)
        begin
          addr_q   <= base_i;
          stride_q <= stride_i;
          count_q  <= count_i;
          issued_q <= '0;
          rcvd_q   <= '0;
          if (count_i == '0)
          begin
            done_q <= 1'b1;  // empty transfer finishes at once.
          end
          else
          begin
            state_q <= ISSUE;
          end
        end
      end
      else
      begin
        if (granted)
        begin
          addr_q   <= addr_q + stride_q;  // wraps at 16 bits.
          issued_q <= issued_q + 1'b1;
          if (issued_q == count_q - 1'b1)
          begin
            state_q <= DRAIN;
          end
        end
        if (received)
        begin
          rcvd_q <= rcvd_q + 1'b1;
          if (rcvd_q == count_q - 1'b1)
          begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
      end
    end
  end

  assign req_o.req = (state_q == ISSUE);
  assign req_o.add = addr_q;
  assign busy_o    = (state_q != IDLE);
  assign done_o    = done_q;

endmodule

//--- source/tcdm_bank.sv
// Single-ported TCDM word bank.
// Grants whenever not stalled and returns read data one cycle later;
// a separate fill port loads its contents.

`timescale 1ns/1ns

module tcdm_bank #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  tcdm_pkg::tcdm_req_t req_i,
  output tcdm_pkg::tcdm_rsp_t rsp_o,
  input  logic                fill_en_i,
  input  tcdm_pkg::addr_t     fill_addr_i,
  input  tcdm_pkg::word_t     fill_data_i
);

  localparam int unsigned IDX_WIDTH = $clog2(MEM_WORDS);

  tcdm_pkg::word_t        mem_q [MEM_WORDS];
  tcdm_pkg::word_t        rdata_q;
  logic                   rvalid_q;
  logic                   gnt;
  logic [IDX_WIDTH-1:0]   rd_idx;
  logic [IDX_WIDTH-1:0]   fill_idx;

  assign gnt      = req_i.req & ~stall_i;  // stall models a conflicting master.
  assign rd_idx   = IDX_WIDTH'(req_i.add % MEM_WORDS);
  assign fill_idx = IDX_WIDTH'(fill_addr_i % MEM_WORDS);

  // A read in the same cycle as a fill to that word sees the old contents.
  always_ff @(posedge clk_i)
  begin
    if (fill_en_i)
    begin
      mem_q[fill_idx] <= fill_data_i;
    end
    if (gnt)
    begin
      rdata_q <= mem_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= gnt;  // one cycle read latency.
    end
  end

  assign rsp_o.gnt     = gnt;
  assign rsp_o.r_valid = rvalid_q;
  assign rsp_o.r_data  = rdata_q;

endmodule

//--- source/load_stream_top.sv
// Strided load stream subsystem.
// Connects the address generator, the load FIFO decoupler and the bank.

`timescale 1ns/1ns

module load_stream_top #(
  parameter int unsigned FIFO_DEPTH = 8,
  parameter int unsigned MEM_WORDS  = 256
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  tcdm_pkg::addr_t  base_i,
  input  tcdm_pkg::count_t stride_i,
  input  tcdm_pkg::count_t count_i,
  input  logic             ready_i,
  input  logic             stall_i,
  input  logic             fill_en_i,
  input  tcdm_pkg::addr_t  fill_addr_i,
  input  tcdm_pkg::word_t  fill_data_i,
  output tcdm_pkg::word_t  data_o,
  output logic             valid_o,
  output logic             busy_o,
  output logic             done_o,
  output logic             idle_o
);

  tcdm_pkg::tcdm_req_t   gen_req;
  tcdm_pkg::tcdm_rsp_t   gen_rsp;
  tcdm_pkg::tcdm_req_t   mem_req;
  tcdm_pkg::tcdm_rsp_t   mem_rsp;
  tcdm_pkg::fifo_flags_t load_flags;

  load_addr_gen i_addr_gen (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear_i  ( clear_i  ),
    .start_i  ( start_i  ),
    .base_i   ( base_i   ),
    .stride_i ( stride_i ),
    .count_i  ( count_i  ),
    .req_o    ( gen_req  ),
    .rsp_i    ( gen_rsp  ),
    .busy_o   ( busy_o   ),
    .done_o   ( done_o   )
  );

  tcdm_fifo_load #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo_load (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .clear_i   ( clear_i    ),
    .ready_i   ( ready_i    ),
    .up_req_i  ( gen_req    ),
    .up_rsp_o  ( gen_rsp    ),
    .mem_req_o ( mem_req    ),
    .mem_rsp_i ( mem_rsp    ),
    .flags_o   ( load_flags )
  );

  tcdm_bank #(
    .MEM_WORDS ( MEM_WORDS )
  ) i_bank (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .stall_i     ( stall_i     ),
    .req_i       ( mem_req     ),
    .rsp_o       ( mem_rsp     ),
    .fill_en_i   ( fill_en_i   ),
    .fill_addr_i ( fill_addr_i ),
    .fill_data_i ( fill_data_i )
  );

  assign data_o  = gen_rsp.r_data;
  assign valid_o = gen_rsp.r_valid;  // same strobe the generator counts.
  assign idle_o  = load_flags.empty;

endmodule

//--- tb/tb_load_stream.sv
// Testbench for the strided load stream subsystem.
// Preloads the bank, runs a table of loads under random stall and ready
// patterns and checks every returned word against the preload rule.

`timescale 1ns/1ns

module tb_load_stream;

  localparam int          CLK_PERIOD = 100;
  localparam int          MEM_WORDS  = 256;
  localparam int          NUM_ROWS   = 7;
  localparam logic [31:0] SEED_INIT  = 32'h4d00e10c;

  typedef struct packed {
    logic [15:0] base;
    logic [15:0] stride;
    logic [15:0] count;
    logic [7:0]  stall_pct;   // chance of stall_i per cycle.
    logic [7:0]  ready_pct;   // chance of ready_i per cycle.
    logic [7:0]  low_cycles;  // ready_i forced low for this long after start.
    logic [7:0]  clear_at;    // clear_i cycle or zero for none.
    logic [7:0]  exp_done;    // expected done_o pulses.
  } row_t;

  // the row after the cleared load checks that a fresh load is clean.
  row_t rows [NUM_ROWS] = '{
    '{16'd0,   16'd1, 16'd8,  8'd0,  8'd100, 8'd0,  8'd0,  8'd1},
    '{16'd16,  16'd3, 16'd20, 8'd50, 8'd100, 8'd0,  8'd0,  8'd1},
    '{16'd40,  16'd1, 16'd24, 8'd0,  8'd100, 8'd40, 8'd0,  8'd1},
    '{16'd250, 16'd5, 16'd6,  8'd0,  8'd100, 8'd0,  8'd0,  8'd1},
    '{16'd100, 16'd2, 16'd30, 8'd25, 8'd70,  8'd0,  8'd10, 8'd0},
    '{16'd7,   16'd7, 16'd12, 8'd25, 8'd70,  8'd0,  8'd0,  8'd1},
    '{16'd5,   16'd1, 16'd0,  8'd0,  8'd100, 8'd0,  8'd0,  8'd1}
  };

  logic             clk_i;
  logic             rst_ni;
  logic             clear_i;
  logic             start_i;
  tcdm_pkg::addr_t  base_i;
  tcdm_pkg::count_t stride_i;
  tcdm_pkg::count_t count_i;
  logic             ready_i;
  logic             stall_i;
  logic             fill_en_i;
  tcdm_pkg::addr_t  fill_addr_i;
  tcdm_pkg::word_t  fill_data_i;
  tcdm_pkg::word_t  data_o;
  logic             valid_o;
  logic             busy_o;
  logic             done_o;
  logic             idle_o;

  integer           seed = SEED_INIT;
  int               errors = 0;
  int               checks = 0;
  int               done_cnt = 0;
  logic             in_window = 1'b0;
  tcdm_pkg::word_t  got_q [$];

  load_stream_top #(
    .FIFO_DEPTH ( 8         ),
    .MEM_WORDS  ( MEM_WORDS )
  ) dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .start_i     ( start_i     ),
    .base_i      ( base_i      ),
    .stride_i    ( stride_i    ),
    .count_i     ( count_i     ),
    .ready_i     ( ready_i     ),
    .stall_i     ( stall_i     ),
    .fill_en_i   ( fill_en_i   ),
    .fill_addr_i ( fill_addr_i ),
    .fill_data_i ( fill_data_i ),
    .data_o      ( data_o      ),
    .valid_o     ( valid_o     ),
    .busy_o      ( busy_o      ),
    .done_o      ( done_o      ),
    .idle_o      ( idle_o      )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic tcdm_pkg::word_t preload_word(input int idx);
    return (tcdm_pkg::word_t'(idx) * 32'h01010101) ^ SEED_INIT;
  endfunction

  // word k of a load sits at base + k * stride, wrapped to 16 bits.
  function automatic tcdm_pkg::word_t expected_word(input row_t row, input int k);
    tcdm_pkg::addr_t addr;
    addr = row.base + tcdm_pkg::addr_t'(k) * row.stride;
    return preload_word(int'(addr) % MEM_WORDS);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic preload_memory();
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      @(negedge clk_i);
      fill_en_i   = 1'b1;
      fill_addr_i = tcdm_pkg::addr_t'(i);
      fill_data_i = preload_word(i);
    end
    @(negedge clk_i);
    fill_en_i = 1'b0;
  endtask

  task automatic drive_cycle(input row_t row, input int cycle);
    int unsigned roll;
    roll      = $unsigned($random(seed)) % 32'd100;
    stall_i   = roll < 32'(row.stall_pct);
    roll      = $unsigned($random(seed)) % 32'd100;
    in_window = cycle < int'(row.low_cycles);
    ready_i   = !in_window && (roll < 32'(row.ready_pct));
  endtask

  task automatic run_row(input int r);
    row_t row;
    int   cycle;
    int   errs_before;
    row         = rows[r];
    errs_before = errors;
    got_q.delete();
    done_cnt = 0;
    base_i   = row.base;
    stride_i = row.stride;
    count_i  = row.count;
    start_i  = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    if (row.count != 0)
    begin
      check_value("busy_o", 32'(busy_o), 32'd1);  // busy rises the cycle after start.
    end
    cycle   = 0;
    while (done_cnt == 0 && (row.clear_at == 0 || cycle < int'(row.clear_at)))
    begin
      drive_cycle(row, cycle);
      @(negedge clk_i);
      cycle++;
    end
    if (row.clear_at != 0)
    begin
      clear_i = 1'b1;  // abort the load while words are in flight.
      @(negedge clk_i);
      clear_i = 1'b0;
      check_value("idle_o", 32'(idle_o), 32'd1);
      check_value("busy_o", 32'(busy_o), 32'd0);
    end
    in_window = 1'b0;
    stall_i   = 1'b0;
    ready_i   = 1'b1;
    repeat (4) @(negedge clk_i);  // late words or a second done would show up here.
    check_value("done_o pulses", 32'(done_cnt), 32'(row.exp_done));
    if (row.clear_at == 0)
    begin
      check_value("word count", 32'(got_q.size()), 32'(row.count));
    end
    else if (got_q.size() > int'(row.count))
    begin
      errors++;
      $display("row %0d returned more words than it requested", r);
    end
    for (int k = 0; k < got_q.size() && k < int'(row.count); k++)
    begin
      check_value("data_o", got_q[k], expected_word(row, k));
    end
    $display("row %0d: base %0d stride %0d count %0d, %0d words, %s", r, row.base,
             row.stride, row.count, got_q.size(), (errors == errs_before) ? "ok" : "FAILED");
  endtask

  // collects the output stream at the rising edge, where it is settled.
  always @(posedge clk_i)
  begin
    if (rst_ni)
    begin
      if (in_window)
      begin
        check_value("valid_o", 32'(valid_o), 32'd0);
      end
      if (valid_o)
      begin
        check_value("idle_o", 32'(idle_o), 32'd0);  // a word on the way out is still buffered.
        got_q.push_back(data_o);
      end
      if (done_o)
      begin
        check_value("busy_o", 32'(busy_o), 32'd0);  // busy falls together with done.
        done_cnt++;
      end
    end
  end

  initial
  begin : watchdog
    int limit;
    limit = 1000;
    foreach (rows[i])
    begin
      limit += 20 * int'(rows[i].count);
    end
    #(limit * CLK_PERIOD);
    $display("the run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    base_i      = '0;
    stride_i    = '0;
    count_i     = '0;
    ready_i     = 1'b1;
    stall_i     = 1'b0;
    fill_en_i   = 1'b0;
    fill_addr_i = '0;
    fill_data_i = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("idle_o", 32'(idle_o), 32'd1);
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("valid_o", 32'(valid_o), 32'd0);
    preload_memory();
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      run_row(r);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
common/tcdm_pkg.sv
source/stream_fifo.sv
tcdm_fifo_load/tcdm_fifo_load.sv
source/load_addr_gen.sv
source/tcdm_bank.sv
source/load_stream_top.sv
tb/tb_load_stream.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the load stream testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_load_stream -Mdir obj_dir

out=$(./obj_dir/Vtb_load_stream)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
